// ==== umi2tl_cfg.svh ====
`ifndef UMI2TL_CFG_SVH
`define UMI2TL_CFG_SVH

// UMI address width
`define UMI2TL_AW 64

// Data width, same on the UMI and TileLink sides
`define UMI2TL_DW 64

// TileLink address width
`define UMI2TL_TL_AW 56

// TileLink source id width
`define UMI2TL_SRCW 4

// Cycles the ready outputs stay low after reset
`define UMI2TL_RESET_GATE 2

`endif

// ==== umi2tl_pkg.sv ====
`default_nettype none

`include "umi2tl_cfg.svh"

package umi2tl_pkg;

    typedef enum logic [4:0] {
        REQ_READ   = 5'd1,
        RESP_READ  = 5'd2,
        REQ_WRITE  = 5'd3,
        RESP_WRITE = 5'd4,
        REQ_ATOMIC = 5'd9
    } umi_opcode_e;

    typedef enum logic [7:0] {
        ADD  = 8'd0,
        AND  = 8'd1,
        OR   = 8'd2,
        XOR  = 8'd3,
        MAX  = 8'd4,
        MIN  = 8'd5,
        MAXU = 8'd6,
        MINU = 8'd7,
        SWAP = 8'd8
    } umi_atype_e;

    typedef enum logic [2:0] {
        PUT_FULL_DATA   = 3'd0,
        ARITHMETIC_DATA = 3'd2,
        LOGICAL_DATA    = 3'd3,
        GET             = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        ACCESS_ACK      = 3'd0,
        ACCESS_ACK_DATA = 3'd1
    } tl_d_opcode_e;

    // qos, prot, eom, eof, ex, user, err and hostid packed into attr
    typedef struct packed {
        umi_opcode_e opcode;
        logic [2:0]  size;
        logic [7:0]  len;
        umi_atype_e  atype;
        logic [7:0]  attr;
    } umi_cmd_t;

    typedef struct packed {
        umi_cmd_t               cmd;
        logic [`UMI2TL_AW-1:0]  dstaddr;
        logic [`UMI2TL_AW-1:0]  srcaddr;
        logic [`UMI2TL_DW-1:0]  data;
    } umi_req_t;

    typedef struct packed {
        tl_a_opcode_e             opcode;
        logic [2:0]               param;
        logic [2:0]               size;
        logic [`UMI2TL_SRCW-1:0]  source;
        logic [`UMI2TL_TL_AW-1:0] address;
        logic [`UMI2TL_DW/8-1:0]  mask;
        logic [`UMI2TL_DW-1:0]    data;
        logic                     corrupt;
    } tl_a_t;

    typedef struct packed {
        tl_d_opcode_e            opcode;
        logic [1:0]              param;
        logic [2:0]              size;
        logic [`UMI2TL_SRCW-1:0] source;
        logic                    sink;
        logic                    denied;
        logic [`UMI2TL_DW-1:0]   data;
        logic                    corrupt;
    } tl_d_t;

    // Byte shift of the data lane inside the 64-bit word
    typedef struct packed {
        umi_cmd_t              cmd;
        logic [`UMI2TL_AW-1:0] dstaddr;
        logic [`UMI2TL_AW-1:0] srcaddr;
        logic [2:0]            shift;
    } req_ctx_t;

endpackage

`default_nettype wire

// ==== umi2tl_txn_track.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "umi2tl_cfg.svh"

module umi2tl_txn_track
    import umi2tl_pkg::*;
(
    input  logic       clk,
    input  logic       nreset,
    input  logic       req_valid,
    input  umi_req_t   req,
    input  logic       resp_done,
    input  logic [2:0] req_shift,
    output logic       req_ready,
    output logic       req_accept,
    output logic       gate_open,
    output req_ctx_t   req_ctx
);

    logic [`UMI2TL_RESET_GATE-1:0] gate_sr;
    logic                          in_flight;
    logic                          done_q;

    // Gate opens once ones reach the last stage after reset
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            gate_sr <= '0;
        end else begin
            gate_sr <= {gate_sr[`UMI2TL_RESET_GATE-2:0], 1'b1};
        end
    end

    assign gate_open  = gate_sr[`UMI2TL_RESET_GATE-1];
    assign req_ready  = gate_open & ~in_flight;
    assign req_accept = req_valid & req_ready;

    // Release of in_flight lags the response transfer by one cycle
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            in_flight <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= resp_done;
            if (req_accept) begin
                in_flight <= 1'b1;
            end else if (done_q) begin
                in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            req_ctx.cmd     <= req.cmd;
            req_ctx.dstaddr <= req.dstaddr;
            req_ctx.srcaddr <= req.srcaddr;
            req_ctx.shift   <= req_shift;
        end
    end

endmodule

`default_nettype wire

// ==== umi2tl_req_map.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "umi2tl_cfg.svh"

module umi2tl_req_map
    import umi2tl_pkg::*;
(
    input  logic       clk,
    input  logic       nreset,
    input  umi_req_t   req,
    input  logic       req_accept,
    output logic [2:0] req_shift,
    output logic       tl_a_valid,
    output tl_a_t      tl_a,
    input  logic       tl_a_ready
);

    logic [16:0]              req_bytes;
    logic [2:0]               a_size;
    logic [`UMI2TL_DW/8-1:0]  a_mask;
    tl_a_opcode_e             a_opcode;
    logic [2:0]               a_param;

    assign req_bytes = (17'd1 << req.cmd.size) * ({9'd0, req.cmd.len} + 17'd1);

    always_comb begin
        case (req_bytes)
            17'd8: begin
                a_size    = 3'd3;
                a_mask    = 8'hff;
                req_shift = 3'd0;
            end
            17'd4: begin
                a_size    = 3'd2;
                a_mask    = 8'h0f;
                req_shift = {req.dstaddr[2], 2'b00};
            end
            17'd2: begin
                a_size    = 3'd1;
                a_mask    = 8'h03;
                req_shift = {req.dstaddr[2:1], 1'b0};
            end
            17'd1: begin
                a_size    = 3'd0;
                a_mask    = 8'h01;
                req_shift = req.dstaddr[2:0];
            end
            default: begin
                a_size    = 3'd0;
                a_mask    = 8'h00;
                req_shift = 3'd0;
            end
        endcase
    end

    // Atomic params follow the TileLink arithmetic and logical encodings
    always_comb begin
        a_opcode = GET;
        a_param  = 3'd0;
        case (req.cmd.opcode)
            REQ_WRITE: a_opcode = PUT_FULL_DATA;
            REQ_ATOMIC: begin
                case (req.cmd.atype)
                    ADD, MAX, MIN, MAXU, MINU: a_opcode = ARITHMETIC_DATA;
                    AND, OR, XOR, SWAP:        a_opcode = LOGICAL_DATA;
                    default:                   a_opcode = GET;
                endcase
                case (req.cmd.atype)
                    ADD:     a_param = 3'd4;
                    MAX:     a_param = 3'd1;
                    MIN:     a_param = 3'd0;
                    MAXU:    a_param = 3'd3;
                    MINU:    a_param = 3'd2;
                    XOR:     a_param = 3'd0;
                    OR:      a_param = 3'd1;
                    AND:     a_param = 3'd2;
                    SWAP:    a_param = 3'd3;
                    default: a_param = 3'd0;
                endcase
            end
            default: a_opcode = GET;
        endcase
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            tl_a_valid <= 1'b0;
        end else if (req_accept) begin
            tl_a_valid <= 1'b1;
        end else if (tl_a_valid && tl_a_ready) begin
            tl_a_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            tl_a.opcode  <= a_opcode;
            tl_a.param   <= a_param;
            tl_a.size    <= a_size;
            tl_a.source  <= '0;
            tl_a.address <= {req.dstaddr[`UMI2TL_TL_AW-1:3], 3'b000};
            tl_a.mask    <= a_mask << req_shift;
            tl_a.data    <= req.data << {req_shift, 3'b000};
            tl_a.corrupt <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== umi2tl_resp_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module umi2tl_resp_map
    import umi2tl_pkg::*;
(
    input  logic     clk,
    input  logic     nreset,
    input  logic     gate_open,
    input  req_ctx_t req_ctx,
    input  logic     tl_d_valid,
    input  tl_d_t    tl_d,
    output logic     tl_d_ready,
    output logic     resp_valid,
    output umi_req_t resp,
    input  logic     resp_ready,
    output logic     resp_done
);

    logic        d_xfer;
    umi_cmd_t    resp_cmd;
    umi_opcode_e resp_opcode;

    // Hold off D while the response slot is still occupied
    assign tl_d_ready = gate_open & (~resp_valid | resp_ready);
    assign d_xfer     = tl_d_valid & tl_d_ready;
    assign resp_done  = resp_valid & resp_ready;

    always_comb begin
        if (tl_d.opcode == ACCESS_ACK_DATA) begin
            resp_opcode = RESP_READ;
        end else begin
            resp_opcode = RESP_WRITE;
        end
    end

    // Request command reused, only the opcode changes
    always_comb begin
        resp_cmd        = req_ctx.cmd;
        resp_cmd.opcode = resp_opcode;
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            resp_valid <= 1'b0;
        end else if (d_xfer) begin
            resp_valid <= 1'b1;
        end else if (resp_done) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (d_xfer) begin
            resp.cmd     <= resp_cmd;
            resp.dstaddr <= req_ctx.srcaddr;
            resp.srcaddr <= req_ctx.dstaddr;
            resp.data    <= tl_d.data >> {req_ctx.shift, 3'b000};
        end
    end

endmodule

`default_nettype wire

// ==== umi2tl.sv ====
`timescale 1ns/1ps
`default_nettype none

module umi2tl
    import umi2tl_pkg::*;
(
    input  logic     clk,
    input  logic     nreset,

    // UMI device side
    input  logic     req_valid,
    input  umi_req_t req,
    output logic     req_ready,
    output logic     resp_valid,
    output umi_req_t resp,
    input  logic     resp_ready,

    // TileLink side
    output logic     tl_a_valid,
    output tl_a_t    tl_a,
    input  logic     tl_a_ready,
    input  logic     tl_d_valid,
    input  tl_d_t    tl_d,
    output logic     tl_d_ready
);

    logic       req_accept;
    logic [2:0] req_shift;
    logic       gate_open;
    logic       resp_done;
    req_ctx_t   req_ctx;

    umi2tl_txn_track txn_track_inst (
        .clk        (clk),
        .nreset     (nreset),
        .req_valid  (req_valid),
        .req        (req),
        .resp_done  (resp_done),
        .req_shift  (req_shift),
        .req_ready  (req_ready),
        .req_accept (req_accept),
        .gate_open  (gate_open),
        .req_ctx    (req_ctx)
    );

    umi2tl_req_map req_map_inst (
        .clk        (clk),
        .nreset     (nreset),
        .req        (req),
        .req_accept (req_accept),
        .req_shift  (req_shift),
        .tl_a_valid (tl_a_valid),
        .tl_a       (tl_a),
        .tl_a_ready (tl_a_ready)
    );

    umi2tl_resp_map resp_map_inst (
        .clk        (clk),
        .nreset     (nreset),
        .gate_open  (gate_open),
        .req_ctx    (req_ctx),
        .tl_d_valid (tl_d_valid),
        .tl_d       (tl_d),
        .tl_d_ready (tl_d_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready),
        .resp_done  (resp_done)
    );

endmodule

`default_nettype wire

// ==== tb_tl_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "umi2tl_cfg.svh"

module tb_tl_memory
    import umi2tl_pkg::*;
(
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  tl_a_valid,
    input  tl_a_t                 tl_a,
    output logic                  tl_a_ready,
    output logic                  tl_d_valid,
    output tl_d_t                 tl_d,
    input  logic                  tl_d_ready,
    input  logic [`UMI2TL_DW-1:0] d_data,
    output tl_a_t                 a_beat,
    output logic [15:0]           a_count
);

    logic       busy;
    logic [1:0] delay;

    always @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            tl_a_ready <= 1'b0;
            tl_d_valid <= 1'b0;
            tl_d       <= '0;
            a_beat     <= '0;
            a_count    <= '0;
            busy       <= 1'b0;
            delay      <= '0;
        end else if (!busy) begin
            // Ready toggles at random while idle
            tl_a_ready <= 1'($urandom % 2);
            if (tl_a_valid && tl_a_ready) begin
                tl_a_ready <= 1'b0;
                a_beat     <= tl_a;
                a_count    <= a_count + 16'd1;
                delay      <= 2'($urandom % 4);
                busy       <= 1'b1;
            end
        end else if (!tl_d_valid) begin
            if (delay == 2'd0) begin
                tl_d_valid   <= 1'b1;
                tl_d.opcode  <= (a_beat.opcode == PUT_FULL_DATA) ? ACCESS_ACK : ACCESS_ACK_DATA;
                tl_d.param   <= '0;
                tl_d.size    <= a_beat.size;
                tl_d.source  <= a_beat.source;
                tl_d.sink    <= 1'b0;
                tl_d.denied  <= 1'b0;
                tl_d.data    <= d_data;
                tl_d.corrupt <= 1'b0;
            end else begin
                delay <= delay - 2'd1;
            end
        end else if (tl_d_ready) begin
            // D beat taken, back to idle
            tl_d_valid <= 1'b0;
            busy       <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb_umi2tl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "umi2tl_cfg.svh"

module tb_umi2tl
    import umi2tl_pkg::*;
();

    localparam int NUM_ROWS = 17;
    localparam int TIMEOUT  = 100;

    typedef struct packed {
        umi_cmd_t              cmd;
        logic [`UMI2TL_AW-1:0] dstaddr;
        logic [`UMI2TL_AW-1:0] srcaddr;
        logic [`UMI2TL_DW-1:0] data;
        logic [`UMI2TL_DW-1:0] d_data;
    } row_t;

    logic                  clk;
    logic                  nreset;
    logic                  req_valid;
    umi_req_t              req;
    logic                  req_ready;
    logic                  resp_valid;
    umi_req_t              resp;
    logic                  resp_ready;
    logic                  tl_a_valid;
    tl_a_t                 tl_a;
    logic                  tl_a_ready;
    logic                  tl_d_valid;
    tl_d_t                 tl_d;
    logic                  tl_d_ready;
    logic [`UMI2TL_DW-1:0] cur_d_data;
    tl_a_t                 a_beat;
    logic [15:0]           a_count;
    row_t                  rows [NUM_ROWS];

    umi2tl umi2tl_inst (
        .clk        (clk),
        .nreset     (nreset),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready),
        .tl_a_valid (tl_a_valid),
        .tl_a       (tl_a),
        .tl_a_ready (tl_a_ready),
        .tl_d_valid (tl_d_valid),
        .tl_d       (tl_d),
        .tl_d_ready (tl_d_ready)
    );

    tb_tl_memory tl_memory_inst (
        .clk        (clk),
        .nreset     (nreset),
        .tl_a_valid (tl_a_valid),
        .tl_a       (tl_a),
        .tl_a_ready (tl_a_ready),
        .tl_d_valid (tl_d_valid),
        .tl_d       (tl_d),
        .tl_d_ready (tl_d_ready),
        .d_data     (cur_d_data),
        .a_beat     (a_beat),
        .a_count    (a_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        resp_ready <= 1'($urandom % 2);
    end

    function automatic umi_cmd_t make_cmd(input umi_opcode_e op, input logic [2:0] size,
                                          input logic [7:0] len, input umi_atype_e atype,
                                          input logic [7:0] attr);
        umi_cmd_t c;
        c.opcode = op;
        c.size   = size;
        c.len    = len;
        c.atype  = atype;
        c.attr   = attr;
        return c;
    endfunction

    function automatic row_t make_row(input umi_cmd_t cmd, input logic [63:0] dst,
                                      input logic [63:0] src, input logic [63:0] data,
                                      input logic [63:0] d_data);
        return {cmd, dst, src, data, d_data};
    endfunction

    // Reads, writes of every size, then the nine atomics
    task automatic load_table();
        rows[0]  = make_row(make_cmd(REQ_READ, 3'd0, 8'd0, ADD, 8'h11),
                            64'h1005, 64'h9000, 64'h0, 64'h8877_6655_4433_2211);
        rows[1]  = make_row(make_cmd(REQ_READ, 3'd1, 8'd0, ADD, 8'h22),
                            64'h0042_0000_1006, 64'h9008, 64'h0, 64'hf0e1_d2c3_b4a5_9687);
        rows[2]  = make_row(make_cmd(REQ_READ, 3'd2, 8'd0, ADD, 8'h33),
                            64'h1004, 64'h9010, 64'h0, 64'h0123_4567_89ab_cdef);
        rows[3]  = make_row(make_cmd(REQ_READ, 3'd3, 8'd0, ADD, 8'h44),
                            64'hff00_0000_0000_3008, 64'h9018, 64'h0, 64'h5a5a_1234_a5a5_5678);
        rows[4]  = make_row(make_cmd(REQ_WRITE, 3'd0, 8'd1, ADD, 8'h55),
                            64'h4002, 64'h9020, 64'hbeef, 64'h1111_2222_3333_4444);
        rows[5]  = make_row(make_cmd(REQ_WRITE, 3'd2, 8'd0, ADD, 8'h66),
                            64'h4004, 64'h9028, 64'hcafe_f00d, 64'h0);
        rows[6]  = make_row(make_cmd(REQ_WRITE, 3'd0, 8'd0, ADD, 8'h77),
                            64'h4007, 64'h9030, 64'h77, 64'hdead_beef_0000_0001);
        rows[7]  = make_row(make_cmd(REQ_WRITE, 3'd3, 8'd0, ADD, 8'h88),
                            64'h4000, 64'h9038, 64'h1122_3344_5566_7788, 64'h0);
        rows[8]  = make_row(make_cmd(REQ_ATOMIC, 3'd3, 8'd0, ADD, 8'h99),
                            64'h5000, 64'h9040, 64'h1, 64'h1111_2222_3333_4444);
        rows[9]  = make_row(make_cmd(REQ_ATOMIC, 3'd2, 8'd0, AND, 8'haa),
                            64'h5004, 64'h9048, 64'h0f0f_0f0f, 64'h1234_5678_9abc_def0);
        rows[10] = make_row(make_cmd(REQ_ATOMIC, 3'd1, 8'd0, OR, 8'hbb),
                            64'h5002, 64'h9050, 64'h00ff, 64'hfedc_ba98_7654_3210);
        rows[11] = make_row(make_cmd(REQ_ATOMIC, 3'd0, 8'd0, XOR, 8'hcc),
                            64'h5001, 64'h9058, 64'h5a, 64'haabb_ccdd_eeff_0011);
        rows[12] = make_row(make_cmd(REQ_ATOMIC, 3'd2, 8'd0, MAX, 8'hdd),
                            64'h5000, 64'h9060, 64'h7fff_ffff, 64'h8000_0001_7000_0002);
        rows[13] = make_row(make_cmd(REQ_ATOMIC, 3'd0, 8'd3, MIN, 8'hee),
                            64'h5004, 64'h9068, 64'h8000_0000, 64'h0102_0304_0506_0708);
        rows[14] = make_row(make_cmd(REQ_ATOMIC, 3'd3, 8'd0, MAXU, 8'hf0),
                            64'h5008, 64'h9070, 64'hffff_ffff_ffff_ffff, 64'h2468_ace0_1357_9bdf);
        rows[15] = make_row(make_cmd(REQ_ATOMIC, 3'd1, 8'd0, MINU, 8'h0f),
                            64'h5006, 64'h9078, 64'h1234, 64'hc3c3_3c3c_a5a5_5a5a);
        rows[16] = make_row(make_cmd(REQ_ATOMIC, 3'd2, 8'd1, SWAP, 8'h5c),
                            64'h5008, 64'h9080, 64'habcd_ef01_2345_6789, 64'h9988_7766_5544_3322);
    endtask

    function automatic int row_bytes(input row_t r);
        return (1 << r.cmd.size) * (r.cmd.len + 1);
    endfunction

    // Natural alignment clears the address bits inside the access
    function automatic logic [2:0] lane_offset(input row_t r);
        logic [2:0] low_bits;
        low_bits = 3'(row_bytes(r) - 1);
        return r.dstaddr[2:0] & ~low_bits;
    endfunction

    function automatic tl_a_t expected_a(input row_t r);
        tl_a_t      a;
        int         bytes;
        logic [2:0] offset;
        logic       logical;
        bytes   = row_bytes(r);
        offset  = lane_offset(r);
        logical = (r.cmd.atype == AND) || (r.cmd.atype == OR) ||
                  (r.cmd.atype == XOR) || (r.cmd.atype == SWAP);
        a = '0;
        for (int i = 0; i < 4; i++) begin
            if ((1 << i) == bytes) a.size = 3'(i);
        end
        a.address = r.dstaddr[`UMI2TL_TL_AW-1:0] & ~56'd7;
        a.mask    = 8'((16'd1 << bytes) - 16'd1) << offset;
        a.data    = r.data << (8 * offset);
        case (r.cmd.opcode)
            REQ_WRITE:  a.opcode = PUT_FULL_DATA;
            REQ_ATOMIC: a.opcode = logical ? LOGICAL_DATA : ARITHMETIC_DATA;
            default:    a.opcode = GET;
        endcase
        if (r.cmd.opcode == REQ_ATOMIC) begin
            case (r.cmd.atype)
                MIN, XOR:   a.param = 3'd0;
                MAX, OR:    a.param = 3'd1;
                MINU, AND:  a.param = 3'd2;
                MAXU, SWAP: a.param = 3'd3;
                default:    a.param = 3'd4;
            endcase
        end
        return a;
    endfunction

    function automatic umi_req_t expected_resp(input row_t r);
        umi_req_t p;
        p.cmd        = r.cmd;
        p.cmd.opcode = (r.cmd.opcode == REQ_WRITE) ? RESP_WRITE : RESP_READ;
        p.dstaddr    = r.srcaddr;
        p.srcaddr    = r.dstaddr;
        p.data       = r.d_data >> (8 * lane_offset(r));
        return p;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        abort_run();
    endtask

    task automatic check_tl_a(input tl_a_t got, input tl_a_t exp, input int idx);
        if (got !== exp) begin
            $display("Error at %0t: row %0d A beat %h, expected %h", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input umi_req_t got, input umi_req_t exp, input int idx);
        if (got !== exp) begin
            $display("Error at %0t: row %0d response %h, expected %h", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        int          cycles;
        logic [15:0] start_count;
        r = rows[idx];
        cycles = 0;
        @(negedge clk);
        while (!req_ready) begin
            cycles++;
            if (cycles > TIMEOUT) report_timeout("req_ready");
            @(negedge clk);
        end
        start_count = a_count;
        @(posedge clk);
        req_valid  <= 1'b1;
        req        <= {r.cmd, r.dstaddr, r.srcaddr, r.data};
        cur_d_data <= r.d_data;
        cycles = 0;
        @(negedge clk);
        while (!(req_valid && req_ready)) begin
            cycles++;
            if (cycles > TIMEOUT) report_timeout("the request transfer");
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        // Request in flight until the response is taken
        cycles = 0;
        @(negedge clk);
        while (!resp_valid) begin
            check_level(req_ready, 1'b0, "req_ready while in flight");
            check_level(tl_d_ready, 1'b1, "tl_d_ready while waiting for D");
            check_level(tl_a_valid && (a_count != start_count), 1'b0, "second A beat");
            cycles++;
            if (cycles > TIMEOUT) report_timeout("resp_valid");
            @(negedge clk);
        end
        check_tl_a(a_beat, expected_a(r), idx);
        check_level(a_count == start_count + 16'd1, 1'b1, "single A beat");
        cycles = 0;
        while (!resp_ready) begin
            check_resp(resp, expected_resp(r), idx);
            check_level(resp_valid, 1'b1, "resp_valid under back-pressure");
            check_level(req_ready, 1'b0, "req_ready under back-pressure");
            check_level(tl_d_ready, 1'b0, "tl_d_ready under back-pressure");
            check_level(tl_a_valid, 1'b0, "tl_a_valid before the response transfer");
            cycles++;
            if (cycles > TIMEOUT) report_timeout("resp_ready");
            @(negedge clk);
        end
        check_resp(resp, expected_resp(r), idx);
        @(posedge clk);
        @(negedge clk);
        check_level(req_ready, 1'b0, "req_ready after the response transfer");
        check_level(a_count == start_count + 16'd1, 1'b1, "single A beat");
    endtask

    initial begin
        void'($urandom(32'h10507d64));
        nreset     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        cur_d_data = '0;
        load_table();
        repeat (3) @(posedge clk);
        nreset <= 1'b1;
        // Ready outputs open on the third negedge after release
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_level(tl_a_valid, 1'b0, "tl_a_valid after reset");
            check_level(resp_valid, 1'b0, "resp_valid after reset");
            check_level(req_ready, i == 2, "req_ready after reset");
            check_level(tl_d_ready, i == 2, "tl_d_ready after reset");
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== umi2tl.f ====
+incdir+.
umi2tl_pkg.sv
umi2tl_txn_track.sv
umi2tl_req_map.sv
umi2tl_resp_map.sv
umi2tl.sv
tb_tl_memory.sv
tb_umi2tl.sv

// ==== Bender.yml ====
package:
  name: umi2tl

sources:
  - include_dirs:
      - .
    files:
      - umi2tl_pkg.sv
      - umi2tl_txn_track.sv
      - umi2tl_req_map.sv
      - umi2tl_resp_map.sv
      - umi2tl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tl_memory.sv
      - tb_umi2tl.sv
